// File: common/smartnic_pkg.sv
package smartnic_pkg;

    // ====================
    // Port and datapath sizes
    // ====================
    localparam int NUM_PORTS = 4;
    localparam int DATA_WID  = 64;
    localparam int KEEP_WID  = DATA_WID / 8;

    // Ports 0-1 are cmac, ports 2-3 are host
    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

    // One AXI-Stream beat, tid carries the source port
    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic [KEEP_WID-1:0] keep;
        logic                last;
        logic                err;
        port_t               tdest;
        port_t               tid;
    } axis_beat_t;

    // Beat tagged with its resolved egress port
    typedef struct packed {
        axis_beat_t beat;
        port_t      egress;
    } routed_beat_t;

    // ====================
    // FIFO depths and credits
    // ====================
    localparam int ARB_FIFO_DEPTH = 4;
    localparam int EGR_FIFO_DEPTH = 4;
    localparam int MAX_FIFO_DEPTH =
        (ARB_FIFO_DEPTH > EGR_FIFO_DEPTH) ? ARB_FIFO_DEPTH : EGR_FIFO_DEPTH;
    localparam int CREDIT_WID = $clog2(MAX_FIFO_DEPTH + 1);

    // ====================
    // Register map
    // ====================
    localparam logic [7:0] REG_ROUTE_MODE   = 8'h00;
    localparam logic [7:0] REG_PKT_CNT_BASE = 8'h04;

    // Per source port, 0 = bypass, 1 = tdest
    typedef logic [NUM_PORTS-1:0] route_mode_t;

endpackage : smartnic_pkg

// File: hw/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter type ITEM_T = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  wr_valid,
    input  ITEM_T wr_item,

    output logic  rd_valid,
    output ITEM_T rd_item,
    input  logic  rd_pop,

    output logic  credit
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    ITEM_T              mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               do_pop;

    // Show-ahead read port
    assign rd_valid = (count != '0);
    assign rd_item  = mem[rd_ptr];
    assign do_pop   = rd_pop && rd_valid;

    // Each pop frees one slot and hands one credit back
    assign credit = do_pop;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WID'(wr_valid) - CNT_WID'(do_pop);
        end
    end

    // Sender must never write without a credit
    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> (count < CNT_WID'(DEPTH)))
        else $error("credit_fifo written while full");

endmodule : credit_fifo

// File: hw/ingress_arbiter.sv
`timescale 1ns/1ps

module ingress_arbiter import smartnic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [NUM_PORTS-1:0] s_valid,
    input  axis_beat_t           s_beat [NUM_PORTS],
    output logic [NUM_PORTS-1:0] s_ready,

    output logic                 out_valid,
    output axis_beat_t           out_beat,
    input  logic                 credit_ret
);

    port_t                 grant;
    logic                  locked;
    port_t                 pick;
    port_t                 sel;
    logic                  take;
    logic [CREDIT_WID-1:0] credits;

    // ====================
    // Round-robin pick
    // ====================
    // Search starts one past the last granted port
    always_comb begin
        logic  found;
        port_t idx;
        found = 1'b0;
        pick  = grant;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = grant + port_t'(k);
            if (!found && s_valid[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    // Hold the grant until the last beat goes through
    assign sel  = locked ? grant : pick;
    assign take = s_valid[sel] && (credits != '0);

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            s_ready[i] = take && (sel == port_t'(i));
        end
    end

    // Stamp the source port into tid
    always_comb begin
        out_beat     = s_beat[sel];
        out_beat.tid = sel;
    end
    assign out_valid = take;

    // ====================
    // Grant and credit state
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            grant   <= port_t'(NUM_PORTS - 1);
            locked  <= 1'b0;
            credits <= CREDIT_WID'(ARB_FIFO_DEPTH);
        end else begin
            if (take) begin
                grant  <= sel;
                locked <= !s_beat[sel].last;
            end
            credits <= credits - CREDIT_WID'(take) + CREDIT_WID'(credit_ret);
        end
    end

    // No other source may get ready in the middle of a packet
    a_grant_held : assert property (@(posedge clk) disable iff (rst)
        (take && !out_beat.last) |=> ((s_ready & ~$past(s_ready)) == '0))
        else $error("arbiter grant moved mid-packet");

    // A wrapped counter would read above the route FIFO depth
    a_credit_range : assert property (@(posedge clk) disable iff (rst)
        credits <= CREDIT_WID'(ARB_FIFO_DEPTH))
        else $error("arbiter credit count out of range");

endmodule : ingress_arbiter

// File: hw/route_stage.sv
`timescale 1ns/1ps

module route_stage import smartnic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_valid,
    input  axis_beat_t           in_beat,
    output logic                 in_pop,

    input  route_mode_t          route_mode,

    output logic                 out_valid,
    output routed_beat_t         out_beat,
    input  logic [NUM_PORTS-1:0] egr_credit
);

    logic                  head_valid;
    axis_beat_t            head_beat;
    logic                  go;
    port_t                 egress;
    logic                  in_pkt;
    port_t                 pkt_port;
    logic [CREDIT_WID-1:0] egr_cnt [NUM_PORTS];

    // Receive FIFO, its pops return credits to the arbiter
    credit_fifo #(
        .ITEM_T (axis_beat_t),
        .DEPTH  (ARB_FIFO_DEPTH)
    ) u_in_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (in_valid),
        .wr_item  (in_beat),
        .rd_valid (head_valid),
        .rd_item  (head_beat),
        .rd_pop   (go),
        .credit   (in_pop)
    );

    // ====================
    // Egress resolution
    // ====================
    // Decided on the first beat, then latched for the packet
    always_comb begin
        if (in_pkt) begin
            egress = pkt_port;
        end else if (route_mode[head_beat.tid]) begin
            egress = head_beat.tdest;
        end else begin
            // cmac i <-> host i+2
            egress = head_beat.tid ^ port_t'(NUM_PORTS / 2);
        end
    end

    assign go = head_valid && (egr_cnt[egress] != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= go;
            if (go) begin
                in_pkt <= !head_beat.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            pkt_port        <= egress;
            out_beat.beat   <= head_beat;
            out_beat.egress <= egress;
        end
    end

    // Per egress FIFO credit counters
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst) begin
                egr_cnt[p] <= CREDIT_WID'(EGR_FIFO_DEPTH);
            end else begin
                egr_cnt[p] <= egr_cnt[p]
                            - CREDIT_WID'(go && (egress == port_t'(p)))
                            + CREDIT_WID'(egr_credit[p]);
            end
        end
    end

endmodule : route_stage

// File: hw/egress_demux.sv
`timescale 1ns/1ps

module egress_demux import smartnic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_valid,
    input  routed_beat_t         in_beat,
    output logic [NUM_PORTS-1:0] egr_credit,

    output logic [NUM_PORTS-1:0] m_valid,
    output axis_beat_t           m_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] m_ready,

    output logic [NUM_PORTS-1:0] pkt_done
);

    logic [NUM_PORTS-1:0] wr_sel;
    logic [NUM_PORTS-1:0] m_xfer;

    // ====================
    // Per-port output queues
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic  mid;
        port_t mid_tid;

        // Steer the beat to its egress queue
        assign wr_sel[p] = in_valid && (in_beat.egress == port_t'(p));

        credit_fifo #(
            .ITEM_T (axis_beat_t),
            .DEPTH  (EGR_FIFO_DEPTH)
        ) u_out_fifo (
            .clk      (clk),
            .rst      (rst),
            .wr_valid (wr_sel[p]),
            .wr_item  (in_beat.beat),
            .rd_valid (m_valid[p]),
            .rd_item  (m_beat[p]),
            .rd_pop   (m_ready[p]),
            .credit   (egr_credit[p])
        );

        assign m_xfer[p]   = m_valid[p] && m_ready[p];
        assign pkt_done[p] = m_xfer[p] && m_beat[p].last;

        // Track the packet in flight on this output
        always_ff @(posedge clk) begin
            if (rst) begin
                mid <= 1'b0;
            end else if (m_xfer[p]) begin
                mid <= !m_beat[p].last;
            end
        end

        always_ff @(posedge clk) begin
            if (m_xfer[p]) begin
                mid_tid <= m_beat[p].tid;
            end
        end

        // Packets from different sources never interleave on one output
        a_no_interleave : assert property (@(posedge clk) disable iff (rst)
            (mid && m_valid[p]) |-> (m_beat[p].tid == mid_tid))
            else $error("egress port %0d interleaved packets", p);
    end : g_port

endmodule : egress_demux

// File: hw/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs import smartnic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 reg_wr,
    input  logic [7:0]           reg_addr,
    input  logic [31:0]          reg_wdata,
    output logic [31:0]          reg_rdata,

    input  logic [NUM_PORTS-1:0] pkt_done,
    output route_mode_t          route_mode
);

    logic [31:0] pkt_cnt [NUM_PORTS];
    logic [7:0]  cnt_offset;
    logic        cnt_hit;

    // ====================
    // Route mode register
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            route_mode <= '0;
        end else if (reg_wr && (reg_addr == REG_ROUTE_MODE)) begin
            route_mode <= reg_wdata[NUM_PORTS-1:0];
        end
    end

    // ====================
    // Per-egress packet counters
    // ====================
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst) begin
                pkt_cnt[p] <= '0;
            end else if (pkt_done[p]) begin
                pkt_cnt[p] <= pkt_cnt[p] + 32'd1;
            end
        end
    end

    // ====================
    // Read mux
    // ====================
    assign cnt_offset = reg_addr - REG_PKT_CNT_BASE;
    assign cnt_hit    = (reg_addr >= REG_PKT_CNT_BASE) &&
                        (reg_addr < (REG_PKT_CNT_BASE + 8'(NUM_PORTS)));

    always_comb begin
        reg_rdata = '0;
        if (reg_addr == REG_ROUTE_MODE) begin
            reg_rdata[NUM_PORTS-1:0] = route_mode;
        end else if (cnt_hit) begin
            reg_rdata = pkt_cnt[cnt_offset[$bits(port_t)-1:0]];
        end
    end

endmodule : ctrl_regs

// File: hw/smartnic_switch.sv
`timescale 1ns/1ps

module smartnic_switch import smartnic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // cmac rx 0/1 and host tx 0/1
    input  logic [NUM_PORTS-1:0] s_axis_valid,
    input  axis_beat_t           s_axis_beat [NUM_PORTS],
    output logic [NUM_PORTS-1:0] s_axis_ready,

    // cmac tx 0/1 and host rx 0/1
    output logic [NUM_PORTS-1:0] m_axis_valid,
    output axis_beat_t           m_axis_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] m_axis_ready,

    input  logic                 reg_wr,
    input  logic [7:0]           reg_addr,
    input  logic [31:0]          reg_wdata,
    output logic [31:0]          reg_rdata
);

    logic                 arb_valid;
    axis_beat_t           arb_beat;
    logic                 arb_credit;

    logic                 rt_valid;
    routed_beat_t         rt_beat;
    logic [NUM_PORTS-1:0] egr_credit;

    logic [NUM_PORTS-1:0] pkt_done;
    route_mode_t          route_mode;

    // ====================
    // Pipeline
    // ====================
    ingress_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .s_valid    (s_axis_valid),
        .s_beat     (s_axis_beat),
        .s_ready    (s_axis_ready),
        .out_valid  (arb_valid),
        .out_beat   (arb_beat),
        .credit_ret (arb_credit)
    );

    route_stage u_route (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (arb_valid),
        .in_beat    (arb_beat),
        .in_pop     (arb_credit),
        .route_mode (route_mode),
        .out_valid  (rt_valid),
        .out_beat   (rt_beat),
        .egr_credit (egr_credit)
    );

    egress_demux u_egress (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (rt_valid),
        .in_beat    (rt_beat),
        .egr_credit (egr_credit),
        .m_valid    (m_axis_valid),
        .m_beat     (m_axis_beat),
        .m_ready    (m_axis_ready),
        .pkt_done   (pkt_done)
    );

    // Control and statistics
    ctrl_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .pkt_done   (pkt_done),
        .route_mode (route_mode)
    );

endmodule : smartnic_switch

// File: tb/tb.sv
`timescale 1ns/1ps

module tb import smartnic_pkg::*; ();

    localparam int MAX_LEN        = 8;
    // Packets per source in bypass, tdest, contention and back-pressure
    localparam int TOTAL_PKTS     = NUM_PORTS * (1 + 2 + 3 + 4);
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * MAX_LEN * 20;

    logic                 clk;
    logic                 rst;
    logic [NUM_PORTS-1:0] s_valid;
    axis_beat_t           s_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] s_ready;
    logic [NUM_PORTS-1:0] m_valid;
    axis_beat_t           m_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] m_ready;
    logic                 reg_wr;
    logic [7:0]           reg_addr;
    logic [31:0]          reg_wdata;
    logic [31:0]          reg_rdata;

    integer      seed = 32'hd5c133c0;
    string       test_name = "init";
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles;
    logic        rand_ready = 1'b0;
    route_mode_t mode_shadow;
    int unsigned exp_cnt [NUM_PORTS];

    // Expected beats, indexed by egress * NUM_PORTS + source
    axis_beat_t  exp_q [NUM_PORTS*NUM_PORTS][$];

    // Monitor results, checked at the next rising edge
    logic [NUM_PORTS-1:0] bad_beat = '0;
    logic [NUM_PORTS-1:0] stray    = '0;
    logic [NUM_PORTS-1:0] mixed    = '0;
    logic [NUM_PORTS-1:0] mid      = '0;
    port_t                mid_tid   [NUM_PORTS];
    axis_beat_t           want_beat [NUM_PORTS];
    axis_beat_t           got_beat  [NUM_PORTS];

    smartnic_switch dut (
        .clk          (clk),
        .rst          (rst),
        .s_axis_valid (s_valid),
        .s_axis_beat  (s_beat),
        .s_axis_ready (s_ready),
        .m_axis_valid (m_valid),
        .m_axis_beat  (m_beat),
        .m_axis_ready (m_ready),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Output ready, random only in the back-pressure test
    initial begin
        m_ready = '1;
        forever begin
            @(posedge clk);
            #1;
            m_ready = rand_ready ? NUM_PORTS'($random(seed)) : '1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles with beats outstanding", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ====================
    // Output monitor
    // ====================
    // Samples at the falling edge, where ready and valid are settled
    initial begin
        axis_beat_t act;
        int         q;
        forever begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                bad_beat[p] = 1'b0;
                stray[p]    = 1'b0;
                mixed[p]    = 1'b0;
                if (!rst && m_valid[p] && m_ready[p]) begin
                    act         = m_beat[p];
                    q           = p * NUM_PORTS + int'(act.tid);
                    got_beat[p] = act;
                    if (exp_q[q].size() == 0) begin
                        stray[p] = 1'b1;
                    end else begin
                        want_beat[p] = exp_q[q].pop_front();
                        bad_beat[p]  = (want_beat[p] != act);
                    end
                    mixed[p]   = mid[p] && (act.tid != mid_tid[p]);
                    mid[p]     = !act.last;
                    mid_tid[p] = act.tid;
                end
            end
        end
    end

    a_reset_quiet : assert property (@(negedge clk)
        (rst || $past(rst)) |-> (m_valid == '0 && s_ready == '0))
        else begin
            errors++;
            $display("[ERROR] %s: m_valid/s_ready expected 0/0, actual %b/%b",
                     test_name, m_valid, s_ready);
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_check
        a_beat_match : assert property (@(posedge clk) !bad_beat[p])
            else begin
                errors++;
                $display("[ERROR] %s: port %0d beat expected %h, actual %h",
                         test_name, p, want_beat[p], got_beat[p]);
            end
        a_beat_known : assert property (@(posedge clk) !stray[p])
            else begin
                errors++;
                $display("%s: port %0d delivered a beat from source %0d never sent there",
                         test_name, p, got_beat[p].tid);
            end
        a_whole_pkt : assert property (@(posedge clk) !mixed[p])
            else begin
                errors++;
                $display("%s: port %0d mixed beats of two packets", test_name, p);
            end
    end : g_check

    // ====================
    // Stimulus tasks
    // ====================
    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
        end else begin
            $display("test %s ok", test_name);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
        if (addr == REG_ROUTE_MODE) begin
            mode_shadow = data[NUM_PORTS-1:0];
        end
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
        reg_addr = addr;
        @(negedge clk);
        a_reg_value : assert (reg_rdata == expected)
            else begin
                errors++;
                $display("[ERROR] %s: register 0x%h expected %0d, actual %0d",
                         test_name, addr, expected, reg_rdata);
            end
        @(posedge clk);
        #1;
    endtask

    task automatic send_pkt(input int src, input int len, input port_t tdest,
                            input logic err);
        axis_beat_t b;
        axis_beat_t want;
        int         egress;
        logic       accepted;
        // tdest mode follows tdest, bypass pairs cmac i with host i+2
        if (mode_shadow[src]) begin
            egress = int'(tdest);
        end else if (src < 2) begin
            egress = src + 2;
        end else begin
            egress = src - 2;
        end
        exp_cnt[egress]++;
        for (int i = 0; i < len; i++) begin
            b.data  = {$random(seed), $random(seed)};
            b.last  = (i == len - 1);
            b.keep  = b.last ? (KEEP_WID'($random(seed)) | KEEP_WID'(1)) : '1;
            b.err   = err && b.last;
            b.tdest = tdest;
            b.tid   = '0;
            want     = b;
            want.tid = port_t'(src);
            exp_q[egress * NUM_PORTS + src].push_back(want);
            s_valid[src] = 1'b1;
            s_beat[src]  = b;
            accepted     = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = s_ready[src];
                @(posedge clk);
                #1;
            end
        end
        s_valid[src] = 1'b0;
    endtask

    task automatic send_burst(input int src, input int npkts, input logic pin_dest,
                              input port_t dest);
        int    rnd;
        port_t tdest;
        for (int n = 0; n < npkts; n++) begin
            rnd   = $random(seed);
            tdest = pin_dest ? dest : rnd[9:8];
            send_pkt(src, (rnd & 7) + 1, tdest, rnd[4]);
        end
    endtask

    // All four sources at once
    task automatic send_all(input int npkts, input logic pin_dest, input port_t dest);
        fork
            send_burst(0, npkts, pin_dest, dest);
            send_burst(1, npkts, pin_dest, dest);
            send_burst(2, npkts, pin_dest, dest);
            send_burst(3, npkts, pin_dest, dest);
        join
    endtask

    function automatic bit scoreboard_empty();
        for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drain();
        while (!scoreboard_empty()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
        a_outputs_idle : assert (m_valid == '0)
            else begin
                errors++;
                $display("%s: outputs still valid after every expected beat arrived",
                         test_name);
            end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst         = 1'b1;
        s_valid     = '0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        mode_shadow = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            s_beat[p]  = '0;
            exp_cnt[p] = 0;
        end

        start_test("reset");
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        finish_test();

        start_test("bypass");
        for (int src = 0; src < NUM_PORTS; src++) begin
            send_burst(src, 1, 1'b0, '0);
        end
        drain();
        finish_test();

        start_test("tdest");
        write_reg(REG_ROUTE_MODE, 32'hf);
        check_reg(REG_ROUTE_MODE, 32'hf);
        send_all(2, 1'b0, '0);
        drain();
        finish_test();

        start_test("contention");
        send_all(3, 1'b1, port_t'(1));
        drain();
        finish_test();

        start_test("backpressure");
        rand_ready = 1'b1;
        send_all(4, 1'b0, '0);
        drain();
        rand_ready = 1'b0;
        finish_test();

        start_test("counters");
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_reg(8'(REG_PKT_CNT_BASE + p), exp_cnt[p]);
        end
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb

// File: build.f
common/smartnic_pkg.sv
hw/credit_fifo.sv
hw/ingress_arbiter.sv
hw/route_stage.sv
hw/egress_demux.sv
hw/ctrl_regs.sv
hw/smartnic_switch.sv
tb/tb.sv

// File: Makefile
# Verilator build and run for the smartnic_switch testbench

VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS
SRCS      := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
